// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = packer_tb
FILELIST = stream_packer.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== design/alu_pipe.sv ====
// execute stage computing the result in its first register and delaying it to the full latency
`timescale 1ns/10ps

module alu_pipe #(
    parameter int lat = 3
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   accept,
    input  packer_pkg::op_fields_t fields,
    output logic                   res_valid,
    output packer_pkg::result_t    res
);
    import packer_pkg::*;

    logic [8:0]  sum9;
    logic [15:0] diff;
    logic [15:0] prod;
    result_t     next_res;

    // first stage
    logic        stage_valid;
    result_t     stage_res;

    // arithmetic in full width
    assign sum9 = {1'b0, fields.x} + {1'b0, fields.y};
    // two's complement, wraps when y > x
    assign diff = {8'd0, fields.x} - {8'd0, fields.y};
    assign prod = fields.x * fields.y;

    always_comb begin
        next_res.illegal = fields.illegal;
        next_res.value   = '0;
        // illegal beats keep value zero
        if (!fields.illegal) begin
            case (fields.kind)
                kind_add: next_res.value = {7'd0, sum9};
                kind_sub: next_res.value = diff;
                kind_and: next_res.value = {8'd0, fields.x & fields.y};
                kind_or:  next_res.value = {8'd0, fields.x | fields.y};
                kind_xor: next_res.value = {8'd0, fields.x ^ fields.y};
                kind_mul: next_res.value = prod;
                default:  next_res.value = '0;
            endcase
        end
    end

    // control bit of stage one
    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= accept;
        end
    end

    // result register, no reset needed on payload
    always_ff @(posedge clock) begin
        stage_res <= next_res;
    end

    // remaining lat-1 stages
    generate
        if (lat > 1) begin : g_tail
            delay_line #(
                .lat       (lat - 1),
                .payload_t (result_t)
            ) tail_delay (
                .clock     (clock),
                .reset     (reset),
                .in_valid  (stage_valid),
                .in_data   (stage_res),
                .out_valid (res_valid),
                .out_data  (res)
            );
        end else begin : g_direct
            assign res_valid = stage_valid;
            assign res       = stage_res;
        end
    endgenerate

endmodule

// ==== design/beat_decode.sv ====
// combinational decoder turning a command beat into operation fields for the execute stage
`timescale 1ns/10ps

module beat_decode (
    input  packer_pkg::beat_t      beat,
    output packer_pkg::op_fields_t fields
);
    import packer_pkg::*;

    op_kind_t   kind;
    logic       illegal;
    logic       swap;

    // opcode to operation kind
    always_comb begin
        kind    = kind_add;
        illegal = 1'b0;
        case (beat.op)
            op_add: begin
                kind = kind_add;
            end
            op_sub: begin
                kind = kind_sub;
            end
            op_and: begin
                kind = kind_and;
            end
            op_or: begin
                kind = kind_or;
            end
            op_xor: begin
                kind = kind_xor;
            end
            op_mul: begin
                kind = kind_mul;
            end
            default: begin
                // still runs as add, execute zeroes the value
                kind    = kind_add;
                illegal = 1'b1;
            end
        endcase
    end

    // flag bit 0 swaps a and b
    assign swap = beat.flags[0];

    always_comb begin
        fields.kind    = kind;
        fields.illegal = illegal;
        if (swap) begin
            fields.x = beat.b;
            fields.y = beat.a;
        end else begin
            fields.x = beat.a;
            fields.y = beat.b;
        end
    end

endmodule

// ==== design/delay_line.sv ====
// fixed-latency register chain carrying any payload type plus a valid bit
`timescale 1ns/10ps

module delay_line #(
    parameter int  lat       = 1,
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // one slot per cycle of latency
    logic [lat-1:0] valid_q;
    payload_t       data_q [lat];

    // valid bits cleared on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < lat; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // payload shifts every cycle
    always_ff @(posedge clock) begin
        data_q[0] <= in_data;
        for (int i = 1; i < lat; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid = valid_q[lat-1];
    assign out_data  = data_q[lat-1];

endmodule

// ==== design/packer_pkg.sv ====
// shared beat, field, result and word types for the stream packer, imported by every design block
package packer_pkg;

    // command beat as it arrives on the input stream
    typedef struct packed {
        logic [3:0] op;
        // bit 0 swaps the operands, the rest ride along untouched
        logic [3:0] flags;
        logic [7:0] a;
        logic [7:0] b;
    } beat_t;

    // opcode codes, 6 to 15 are illegal
    localparam logic [3:0] op_add = 4'd0;
    localparam logic [3:0] op_sub = 4'd1;
    localparam logic [3:0] op_and = 4'd2;
    localparam logic [3:0] op_or  = 4'd3;
    localparam logic [3:0] op_xor = 4'd4;
    localparam logic [3:0] op_mul = 4'd5;

    // operation selected by the decoder
    typedef enum logic [2:0] {
        kind_add,
        kind_sub,
        kind_and,
        kind_or,
        kind_xor,
        kind_mul
    } op_kind_t;

    // decoded fields, operands already swapped
    typedef struct packed {
        op_kind_t   kind;
        logic [7:0] x;
        logic [7:0] y;
        logic       illegal;
    } op_fields_t;

    // execute result
    typedef struct packed {
        logic        illegal;
        logic [15:0] value;
    } result_t;

    // result and beat joined, order picked at the top level
    typedef logic [$bits(result_t)+$bits(beat_t)-1:0] packed_word_t;

    // fifo must hold every beat still in flight when back-pressure starts
    function automatic int fifo_depth(input int lat);
        return (lat + 2 > 4) ? lat + 2 : 4;
    endfunction

endpackage

// ==== design/packer_top.sv ====
// top level of the stream result packer, wires decode, execute and result stages
`timescale 1ns/10ps

module packer_top #(
    parameter int lat            = 3,
    parameter bit result_at_head = 1'b1
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     in_valid,
    input  packer_pkg::beat_t        in_beat,
    input  logic                     out_ready,
    output logic                     in_ready,
    output logic                     out_valid,
    output packer_pkg::packed_word_t out_word
);
    import packer_pkg::*;

    op_fields_t fields;
    result_t    res;
    logic       accept;

    // upstream stalls whenever downstream does
    assign in_ready = out_ready;
    // single handshake point for both chains
    assign accept   = in_valid && in_ready;

    beat_decode decode (
        .beat   (in_beat),
        .fields (fields)
    );

    alu_pipe #(
        .lat       (lat)
    ) execute (
        .clock     (clock),
        .reset     (reset),
        .accept    (accept),
        .fields    (fields),
        // chains are the same length, result stage needs no valid
        .res_valid (),
        .res       (res)
    );

    result_planer #(
        .lat            (lat),
        .result_at_head (result_at_head)
    ) planer (
        .clock          (clock),
        .reset          (reset),
        .accept         (accept),
        .beat           (in_beat),
        .res            (res),
        .out_ready      (out_ready),
        .out_valid      (out_valid),
        .out_word       (out_word)
    );

endmodule

// ==== design/result_planer.sv ====
// result stage joining the delayed beat with its execute result and buffering words to the output
`timescale 1ns/10ps

module result_planer #(
    parameter int lat            = 3,
    parameter bit result_at_head = 1'b1
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     accept,
    input  packer_pkg::beat_t        beat,
    input  packer_pkg::result_t      res,
    input  logic                     out_ready,
    output logic                     out_valid,
    output packer_pkg::packed_word_t out_word
);
    import packer_pkg::*;

    // room for every beat still in flight
    localparam int depth = fifo_depth(lat);

    logic         lat_valid;
    beat_t        lat_beat;
    packed_word_t joined;
    logic         fifo_empty;

    // beat delayed to line up with res
    delay_line #(
        .lat       (lat),
        .payload_t (beat_t)
    ) beat_delay (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (accept),
        .in_data   (beat),
        .out_valid (lat_valid),
        .out_data  (lat_beat)
    );

    // result on the upper bits when at head
    assign joined = result_at_head ? {res, lat_beat} : {lat_beat, res};

    stream_fifo #(
        .depth  (depth),
        .item_t (packed_word_t)
    ) out_fifo (
        .clock  (clock),
        .reset  (reset),
        .wr_en  (lat_valid),
        .wdata  (joined),
        .rd_en  (out_ready),
        .rdata  (out_word),
        .empty  (fifo_empty),
        .full   ()
    );

    assign out_valid = !fifo_empty;

endmodule

// ==== design/stream_fifo.sv ====
// first-word-fall-through circular FIFO for any item type, shows the oldest word on rdata
`timescale 1ns/10ps

module stream_fifo #(
    parameter int  depth  = 4,
    parameter type item_t = logic
) (
    input  logic  clock,
    input  logic  reset,
    input  logic  wr_en,
    input  item_t wdata,
    input  logic  rd_en,
    output item_t rdata,
    output logic  empty,
    output logic  full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    // storage, no reset on data
    item_t              mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               do_write;
    logic               do_read;

    // drop writes when full and reads when empty
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));

    // head of queue falls through
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap at depth, which need not be a power of two
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            if (wr_ptr == ptr_w'(depth - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            if (rd_ptr == ptr_w'(depth - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== sim/packer_tb.sv ====
// testbench for the stream packer checking random beats under back-pressure against a queue model
`timescale 1ns/10ps

module packer_tb;
    import packer_pkg::*;

    // matches the DUT default latency
    localparam int lat           = 3;
    localparam int num_beats     = 2000;
    localparam int stream_cycles = 50;
    localparam int wait_limit    = 200;
    localparam int traffic_limit = 50000;

    logic         clock;
    logic         reset;
    logic         in_valid;
    beat_t        in_beat;
    logic         out_ready;
    logic         in_ready;
    logic         out_valid;
    packed_word_t out_word;

    integer       seed;
    packed_word_t expected_q [$];
    int           accepted_count;

    packer_top uut (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

    // 4 ns period
    always #2 clock = ~clock;

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual,
                     expected);
            $display("RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t ns waiting for %s", $time, what);
        $display("RESULT: FAIL");
        $fatal(1, "wait timed out");
    endtask

    // true with the given percentage
    function automatic bit chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    // mostly legal opcodes with some fully random ones for codes 6 to 15
    function automatic beat_t random_beat();
        logic [31:0] r;
        beat_t       b;
        r = $random(seed);
        b = r[23:0];
        if (r[31:30] != 2'b00) begin
            b.op = {1'b0, r[26:24]} % 4'd6;
        end
        return b;
    endfunction

    // reference model with the result at the head and the beat untouched below it
    function automatic packed_word_t expected_word(input beat_t beat);
        logic [7:0]  x;
        logic [7:0]  y;
        logic [15:0] value;
        logic        illegal;
        x       = beat.flags[0] ? beat.b : beat.a;
        y       = beat.flags[0] ? beat.a : beat.b;
        illegal = 1'b0;
        case (beat.op)
            op_add:  value = 16'(x) + 16'(y);
            op_sub:  value = 16'(x) - 16'(y);
            op_and:  value = {8'd0, x & y};
            op_or:   value = {8'd0, x | y};
            op_xor:  value = {8'd0, x ^ y};
            op_mul:  value = 16'(x) * 16'(y);
            default: begin
                illegal = 1'b1;
                value   = 16'd0;
            end
        endcase
        return {illegal, value, beat};
    endfunction

    // monitor at the falling edge where inputs and outputs are settled for the next rising edge
    always @(negedge clock) begin
        if (!reset) begin
            // input ready simply follows the output ready
            check_value(64'(in_ready), 64'(out_ready), "in_ready against out_ready");
            if (in_valid && out_ready) begin
                expected_q.push_back(expected_word(in_beat));
                accepted_count++;
            end
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    $display("Output word %h at %0t ns has no accepted beat", out_word, $time);
                    $display("RESULT: FAIL");
                    $fatal(1, "extra output word");
                end else begin
                    check_value(64'(out_word), 64'(expected_q.pop_front()), "output word");
                end
            end
        end
    end

    task automatic apply_reset();
        for (int i = 1; i <= 10; i++) begin
            @(posedge clock);
            if (i == 10) begin
                reset <= 1'b0;
            end
            @(negedge clock);
            check_value(64'(out_valid), 64'd0, "out_valid during reset");
        end
        @(posedge clock);
        @(negedge clock);
        check_value(64'(out_valid), 64'd0, "out_valid after reset");
    endtask

    // edges counted from the one that raises in_valid
    task automatic measure_latency();
        int edges;
        @(posedge clock);
        in_valid  <= 1'b1;
        in_beat   <= random_beat();
        out_ready <= 1'b1;
        edges = 0;
        do begin
            @(posedge clock);
            in_valid <= 1'b0;
            edges++;
            @(negedge clock);
            if (edges > wait_limit) begin
                report_timeout("the first word in the latency test");
            end
        end while (!out_valid);
        check_value(64'(edges), 64'(lat + 1), "edges until out_valid");
    endtask

    // both sides open so the output must not gap once it starts
    task automatic stream_burst();
        int sent;
        int seen;
        int waited;
        bit started;
        sent    = 0;
        seen    = 0;
        waited  = 0;
        started = 1'b0;
        while (seen < stream_cycles) begin
            @(posedge clock);
            out_ready <= 1'b1;
            if (sent < stream_cycles) begin
                in_valid <= 1'b1;
                in_beat  <= random_beat();
                sent++;
            end else begin
                in_valid <= 1'b0;
            end
            @(negedge clock);
            if (started) begin
                check_value(64'(out_valid), 64'd1, "out_valid while streaming");
            end
            if (out_valid) begin
                started = 1'b1;
                seen++;
            end
            waited++;
            if (waited > wait_limit) begin
                report_timeout("the streaming words");
            end
        end
    endtask

    // source holds a beat until taken while the sink stalls at random and in 8-cycle bursts
    task automatic random_traffic();
        int cycles;
        int stall_left;
        bit done;
        cycles     = 0;
        stall_left = 0;
        done       = 1'b0;
        while (!done) begin
            @(posedge clock);
            if ((in_valid && in_ready) || !in_valid) begin
                if (accepted_count >= num_beats) begin
                    in_valid <= 1'b0;
                    done = 1'b1;
                end else begin
                    in_valid <= chance(70);
                    in_beat  <= random_beat();
                end
            end
            if (stall_left > 0) begin
                out_ready <= 1'b0;
                stall_left--;
            end else if (chance(3)) begin
                out_ready <= 1'b0;
                stall_left = 7;
            end else begin
                out_ready <= chance(60);
            end
            cycles++;
            if (cycles > traffic_limit) begin
                report_timeout("all random beats to be accepted");
            end
        end
    endtask

    // out_valid has to stay low longer than the pipeline before the model is looked at
    task automatic drain_output();
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        @(posedge clock);
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        while (quiet < lat + 2) begin
            @(negedge clock);
            if (out_valid) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            waited++;
            if (waited > wait_limit) begin
                report_timeout("the output to drain");
            end
        end
        // every accepted beat must have come out by now
        check_value(64'(expected_q.size()), 64'd0, "words left in model queue");
    endtask

    initial begin
        seed           = 32'h28066257;
        clock          = 1'b0;
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_beat        = '0;
        out_ready      = 1'b0;
        accepted_count = 0;
        apply_reset();
        measure_latency();
        drain_output();
        stream_burst();
        drain_output();
        random_traffic();
        drain_output();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== stream_packer.f ====
design/packer_pkg.sv
design/beat_decode.sv
design/delay_line.sv
design/alu_pipe.sv
design/stream_fifo.sv
design/result_planer.sv
design/packer_top.sv
sim/packer_tb.sv
